// ==== Bender.yml ====
package:
  name: accel

sources:
  - files:
      - logic/accel_pkg.sv
      - logic/stream_if.sv
      - logic/dram_reader.sv
      - logic/lane_alu.sv
      - logic/dram_writer.sv
      - logic/accel_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/dram_model.sv
      - test/accel_tb.sv

// ==== logic/accel_pkg.sv ====
package accel_pkg;

    // ==============================
    // Widths
    // ==============================

    // One signed lane inside a data word
    localparam int LANE_W = 8;

    // DRAM word address
    localparam int ADDR_W = 16;

    // Word count of one job
    localparam int LEN_W = 16;

    // ==============================
    // Lane operations
    // ==============================

    // Applied to every lane of every word
    typedef enum logic [1:0] {
        OP_COPY = 2'd0,
        OP_RELU = 2'd1,
        OP_NEG  = 2'd2,
        OP_ABS  = 2'd3
    } accel_op_e;

endpackage

// ==== logic/accel_top.sv ====
`timescale 1ns/1ns

module accel_top #(
    parameter int DATA_W = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  accel_pkg::accel_op_e         op,
    input  logic [accel_pkg::ADDR_W-1:0] src_base,
    input  logic [accel_pkg::ADDR_W-1:0] dst_base,
    input  logic [accel_pkg::LEN_W-1:0]  word_count,
    // Read command and data
    input  logic                         rd_cmd_ready,
    output logic                         rd_cmd_valid,
    output logic [accel_pkg::ADDR_W-1:0] rd_cmd_addr,
    output logic [accel_pkg::LEN_W-1:0]  rd_cmd_len,
    input  logic                         rd_valid,
    input  logic [DATA_W-1:0]            rd_data,
    input  logic                         rd_last,
    output logic                         rd_ready,
    // Write command and data
    input  logic                         wr_cmd_ready,
    output logic                         wr_cmd_valid,
    output logic [accel_pkg::ADDR_W-1:0] wr_cmd_addr,
    output logic [accel_pkg::LEN_W-1:0]  wr_cmd_len,
    output logic                         wr_valid,
    output logic [DATA_W-1:0]            wr_data,
    output logic                         wr_last,
    input  logic                         wr_ready,
    output logic                         done
);

    // Writer tells the reader a job is open
    logic busy;

    // ==============================
    // Stage links
    // ==============================
    stream_if #(.DATA_W(DATA_W)) s_rd ();
    stream_if #(.DATA_W(DATA_W)) s_alu ();

    dram_reader #(.DATA_W(DATA_W)) u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .src_base     (src_base),
        .word_count   (word_count),
        .rd_cmd_valid (rd_cmd_valid),
        .rd_cmd_ready (rd_cmd_ready),
        .rd_cmd_addr  (rd_cmd_addr),
        .rd_cmd_len   (rd_cmd_len),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd_data      (rd_data),
        .rd_last      (rd_last),
        .busy         (busy),
        .out          (s_rd)
    );

    // Registered lane stage
    lane_alu #(.DATA_W(DATA_W)) u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .op    (op),
        .in    (s_rd),
        .out   (s_alu)
    );

    dram_writer #(.DATA_W(DATA_W)) u_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .dst_base     (dst_base),
        .word_count   (word_count),
        .wr_cmd_valid (wr_cmd_valid),
        .wr_cmd_ready (wr_cmd_ready),
        .wr_cmd_addr  (wr_cmd_addr),
        .wr_cmd_len   (wr_cmd_len),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr_data      (wr_data),
        .wr_last      (wr_last),
        .in           (s_alu),
        .busy         (busy),
        .done         (done)
    );

endmodule

// ==== logic/dram_reader.sv ====
`timescale 1ns/1ns

module dram_reader #(
    parameter int DATA_W = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [accel_pkg::ADDR_W-1:0] src_base,
    input  logic [accel_pkg::LEN_W-1:0]  word_count,
    output logic                         rd_cmd_valid,
    input  logic                         rd_cmd_ready,
    output logic [accel_pkg::ADDR_W-1:0] rd_cmd_addr,
    output logic [accel_pkg::LEN_W-1:0]  rd_cmd_len,
    input  logic                         rd_valid,
    output logic                         rd_ready,
    input  logic [DATA_W-1:0]            rd_data,
    input  logic                         rd_last,
    input  logic                         busy,
    stream_if.source                     out
);
    import accel_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_CMD,
        RD_STREAM
    } rd_state_e;

    rd_state_e        state;
    logic [LEN_W-1:0] beat_cnt;
    logic             job_go;
    logic             streaming;
    logic             beat_fire;
    logic             final_beat;

    // New job only when the writer side is idle too
    assign job_go    = start && !busy && (state == RD_IDLE);
    assign streaming = (state == RD_STREAM);

    // ==============================
    // Read data pass-through
    // ==============================

    // No register on this path
    assign out.valid = rd_valid && streaming;
    assign out.data  = rd_data;
    assign out.last  = rd_last;
    // Ready held low outside a job
    assign rd_ready  = out.ready && streaming;

    assign beat_fire  = out.valid && out.ready;
    assign final_beat = (beat_cnt == rd_cmd_len - LEN_W'(1));

    assign rd_cmd_valid = (state == RD_CMD);

    // Command fields captured on start
    always_ff @(posedge clk) begin
        if (job_go) begin
            rd_cmd_addr <= src_base;
            rd_cmd_len  <= word_count;
        end
    end

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RD_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (job_go) begin
                        state    <= RD_CMD;
                        beat_cnt <= '0;
                    end
                end
                RD_CMD: begin
                    // Wait for DRAM to take the command
                    if (rd_cmd_ready) begin
                        state <= RD_STREAM;
                    end
                end
                RD_STREAM: begin
                    if (beat_fire) begin
                        beat_cnt <= beat_cnt + LEN_W'(1);
                        if (final_beat) begin
                            state <= RD_IDLE;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Command stays put while stalled
    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rd_cmd_valid && !rd_cmd_ready |=>
            rd_cmd_valid && $stable(rd_cmd_addr) && $stable(rd_cmd_len));

    // DRAM last flag lines up with our own count
    a_last_count: assert property (@(posedge clk) disable iff (!rst_n)
        beat_fire |-> (rd_last == final_beat));

endmodule

// ==== logic/dram_writer.sv ====
`timescale 1ns/1ns

module dram_writer #(
    parameter int DATA_W = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [accel_pkg::ADDR_W-1:0] dst_base,
    input  logic [accel_pkg::LEN_W-1:0]  word_count,
    output logic                         wr_cmd_valid,
    input  logic                         wr_cmd_ready,
    output logic [accel_pkg::ADDR_W-1:0] wr_cmd_addr,
    output logic [accel_pkg::LEN_W-1:0]  wr_cmd_len,
    output logic                         wr_valid,
    input  logic                         wr_ready,
    output logic [DATA_W-1:0]            wr_data,
    output logic                         wr_last,
    stream_if.sink                       in,
    output logic                         busy,
    output logic                         done
);
    import accel_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_CMD,
        WR_STREAM,
        WR_DONE
    } wr_state_e;

    wr_state_e        state;
    logic [LEN_W-1:0] beat_cnt;
    logic             job_go;
    logic             streaming;
    logic             beat_fire;
    logic             final_beat;

    // ==============================
    // Job status
    // ==============================

    // Job runs from command until the final write
    assign busy   = (state == WR_CMD) || (state == WR_STREAM);
    // Held until the next start
    assign done   = (state == WR_DONE);
    assign job_go = start && !busy;

    assign streaming    = (state == WR_STREAM);
    assign wr_cmd_valid = (state == WR_CMD);

    // Stream gated onto the write channel after the command
    assign wr_valid  = in.valid && streaming;
    assign wr_data   = in.data;
    assign in.ready  = wr_ready && streaming;

    assign beat_fire  = wr_valid && wr_ready;
    assign final_beat = (beat_cnt == wr_cmd_len - LEN_W'(1));
    // Last flag taken from the local count
    assign wr_last    = wr_valid && final_beat;

    // Command fields captured on start
    always_ff @(posedge clk) begin
        if (job_go) begin
            wr_cmd_addr <= dst_base;
            wr_cmd_len  <= word_count;
        end
    end

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                WR_IDLE, WR_DONE: begin
                    if (job_go) begin
                        state    <= WR_CMD;
                        beat_cnt <= '0;
                    end
                end
                WR_CMD: begin
                    if (wr_cmd_ready) begin
                        state <= WR_STREAM;
                    end
                end
                WR_STREAM: begin
                    if (beat_fire) begin
                        beat_cnt <= beat_cnt + LEN_W'(1);
                        // Done shows up on the next cycle
                        if (final_beat) begin
                            state <= WR_DONE;
                        end
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Forwarded last agrees with the writer count
    a_last_match: assert property (@(posedge clk) disable iff (!rst_n)
        beat_fire |-> (in.last == final_beat));

endmodule

// ==== logic/lane_alu.sv ====
`timescale 1ns/1ns

module lane_alu #(
    parameter int DATA_W = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  accel_pkg::accel_op_e op,
    stream_if.sink               in,
    stream_if.source             out
);
    import accel_pkg::*;

    localparam int LANES = DATA_W / LANE_W;

    accel_op_e         op_q;
    logic              active;
    logic              job_go;
    logic              in_fire;
    logic              out_fire;
    logic [DATA_W-1:0] res;
    logic              out_valid_q;
    logic [DATA_W-1:0] out_data_q;
    logic              out_last_q;

    // One signed lane through the selected operation
    function automatic logic [LANE_W-1:0] lane_op(input accel_op_e f,
                                                  input logic signed [LANE_W-1:0] x);
        logic signed [LANE_W-1:0] min_v;
        logic signed [LANE_W-1:0] max_v;
        logic signed [LANE_W-1:0] neg_sat;
        min_v = {1'b1, {(LANE_W-1){1'b0}}};
        max_v = ~min_v;
        // Most negative value has no positive twin
        neg_sat = (x == min_v) ? max_v : -x;
        case (f)
            OP_RELU: lane_op = x[LANE_W-1] ? '0 : x;
            OP_NEG:  lane_op = neg_sat;
            OP_ABS:  lane_op = x[LANE_W-1] ? neg_sat : x;
            default: lane_op = x;
        endcase
    endfunction

    // ==============================
    // Opcode capture
    // ==============================

    // Ignore start while a job is still flowing through
    assign job_go = start && !active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q   <= OP_COPY;
            active <= 1'b0;
        end else if (job_go) begin
            op_q   <= op;
            active <= 1'b1;
        end else if (out_fire && out_last_q) begin
            active <= 1'b0;
        end
    end

    // Every lane in parallel
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            res[i*LANE_W +: LANE_W] = lane_op(op_q, in.data[i*LANE_W +: LANE_W]);
        end
    end

    // ==============================
    // Output register
    // ==============================
    assign in_fire  = in.valid && in.ready;
    assign out_fire = out_valid_q && out.ready;
    // Take a word when empty or draining this cycle
    assign in.ready = !out_valid_q || out.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (in_fire) begin
            out_valid_q <= 1'b1;
        end else if (out_fire) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data_q <= res;
            out_last_q <= in.last;
        end
    end

    assign out.valid = out_valid_q;
    assign out.data  = out_data_q;
    assign out.last  = out_last_q;

    // Stalled word is held unchanged
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out.valid && !out.ready |=>
            out.valid && $stable(out.data) && $stable(out.last));

endmodule

// ==== logic/stream_if.sv ====
`timescale 1ns/1ns

interface stream_if #(
    parameter int DATA_W = 32
);

    // Beat moves when valid and ready are both high
    logic              valid;
    logic              ready;
    logic [DATA_W-1:0] data;
    // Final word of the job
    logic              last;

    // Producer side
    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

// ==== tb.f ====
logic/accel_pkg.sv
logic/stream_if.sv
logic/dram_reader.sv
logic/lane_alu.sv
logic/dram_writer.sv
logic/accel_top.sv
test/tb_clock.sv
test/dram_model.sv
test/accel_tb.sv

// ==== test/accel_tb.sv ====
`timescale 1ns/1ns

module accel_tb;
    import accel_pkg::*;

    localparam int DATA_W      = 32;
    localparam int LANES       = DATA_W / LANE_W;
    localparam int DEPTH       = 1024;
    localparam int RST_CYC     = 16;
    // Seven jobs, five of 16 words plus one of 64 and one of 32
    localparam int N_JOBS      = 7;
    localparam int TOTAL_WORDS = 5 * 16 + 64 + 32;
    localparam int CYCLE_LIMIT = RST_CYC + 8 * TOTAL_WORDS + 50 * N_JOBS;

    logic              clk;
    logic              rst_n;
    logic              start;
    accel_op_e         op;
    logic [ADDR_W-1:0] src_base;
    logic [ADDR_W-1:0] dst_base;
    logic [LEN_W-1:0]  word_count;
    logic              stall_en;

    logic              rd_cmd_valid;
    logic              rd_cmd_ready;
    logic [ADDR_W-1:0] rd_cmd_addr;
    logic [LEN_W-1:0]  rd_cmd_len;
    logic              rd_valid;
    logic              rd_ready;
    logic [DATA_W-1:0] rd_data;
    logic              rd_last;
    logic              wr_cmd_valid;
    logic              wr_cmd_ready;
    logic [ADDR_W-1:0] wr_cmd_addr;
    logic [LEN_W-1:0]  wr_cmd_len;
    logic              wr_valid;
    logic              wr_ready;
    logic [DATA_W-1:0] wr_data;
    logic              wr_last;
    logic              done;

    // Bookkeeping
    string             test_name;
    int                errors;
    int                errs_before;
    int                tests_run;
    int                tests_failed;
    int                cycles;
    int                wr_beats;
    int                rd_cmds;
    int                wr_cmds;
    // Start sent while idle, and start sent during a job
    logic              start_ok;
    logic              start_busy;
    logic [ADDR_W-1:0] exp_src;
    logic [ADDR_W-1:0] exp_dst;
    logic [LEN_W-1:0]  exp_len;

    tb_clock #(.PERIOD(40)) u_clk (.clk(clk));

    dram_model #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_dram (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_en     (stall_en),
        .rd_cmd_valid (rd_cmd_valid),
        .rd_cmd_ready (rd_cmd_ready),
        .rd_cmd_addr  (rd_cmd_addr),
        .rd_cmd_len   (rd_cmd_len),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd_data      (rd_data),
        .rd_last      (rd_last),
        .wr_cmd_valid (wr_cmd_valid),
        .wr_cmd_ready (wr_cmd_ready),
        .wr_cmd_addr  (wr_cmd_addr),
        .wr_cmd_len   (wr_cmd_len),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr_data      (wr_data)
    );

    accel_top #(.DATA_W(DATA_W)) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .op           (op),
        .src_base     (src_base),
        .dst_base     (dst_base),
        .word_count   (word_count),
        .rd_cmd_ready (rd_cmd_ready),
        .rd_cmd_valid (rd_cmd_valid),
        .rd_cmd_addr  (rd_cmd_addr),
        .rd_cmd_len   (rd_cmd_len),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_last      (rd_last),
        .rd_ready     (rd_ready),
        .wr_cmd_ready (wr_cmd_ready),
        .wr_cmd_valid (wr_cmd_valid),
        .wr_cmd_addr  (wr_cmd_addr),
        .wr_cmd_len   (wr_cmd_len),
        .wr_valid     (wr_valid),
        .wr_data      (wr_data),
        .wr_last      (wr_last),
        .wr_ready     (wr_ready),
        .done         (done)
    );

    // ==============================
    // Reference lane rules
    // ==============================
    function automatic logic [DATA_W-1:0] ref_word(input accel_op_e f,
                                                   input logic [DATA_W-1:0] w);
        logic [DATA_W-1:0] r;
        int                v;
        int                q;
        int                top;
        top = 2 ** (LANE_W - 1) - 1;
        for (int i = 0; i < LANES; i++) begin
            v = $signed(w[i*LANE_W +: LANE_W]);
            case (f)
                OP_RELU: q = (v < 0) ? 0 : v;
                OP_NEG:  q = -v;
                OP_ABS:  q = (v < 0) ? -v : v;
                default: q = v;
            endcase
            // Only +128 can overflow a lane
            if (q > top) begin
                q = top;
            end
            r[i*LANE_W +: LANE_W] = q[LANE_W-1:0];
        end
        return r;
    endfunction

    // Per-job counters, cleared by an accepted start
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_beats <= 0;
            rd_cmds  <= 0;
            wr_cmds  <= 0;
        end else if (start_ok) begin
            wr_beats <= 0;
            rd_cmds  <= 0;
            wr_cmds  <= 0;
        end else begin
            if (wr_valid && wr_ready) begin
                wr_beats <= wr_beats + 1;
            end
            if (rd_cmd_valid && rd_cmd_ready) begin
                rd_cmds <= rd_cmds + 1;
            end
            if (wr_cmd_valid && wr_cmd_ready) begin
                wr_cmds <= wr_cmds + 1;
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ==============================
    // Protocol checks
    // ==============================
    a_rd_cmd_fields: assert property (@(posedge clk) disable iff (!rst_n)
        rd_cmd_valid |-> (rd_cmd_addr == exp_src) && (rd_cmd_len == exp_len))
        else begin
            errors++;
            $display("error %s: read command expected %0h/%0d actual %0h/%0d",
                     test_name, exp_src, exp_len, rd_cmd_addr, rd_cmd_len);
        end

    a_wr_cmd_fields: assert property (@(posedge clk) disable iff (!rst_n)
        wr_cmd_valid |-> (wr_cmd_addr == exp_dst) && (wr_cmd_len == exp_len))
        else begin
            errors++;
            $display("error %s: write command expected %0h/%0d actual %0h/%0d",
                     test_name, exp_dst, exp_len, wr_cmd_addr, wr_cmd_len);
        end

    // Both commands one edge after the start cycle
    a_cmd_rise: assert property (@(posedge clk) disable iff (!rst_n)
        start_ok |=> rd_cmd_valid && wr_cmd_valid)
        else begin
            errors++;
            $display("%s: commands did not rise after an accepted start", test_name);
        end

    a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
        start_busy |=> !rd_cmd_valid && !wr_cmd_valid && !done)
        else begin
            errors++;
            $display("%s: start during a job was not ignored", test_name);
        end

    a_wr_last: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && wr_ready |-> (wr_last == (wr_beats == int'(exp_len) - 1)))
        else begin
            errors++;
            $display("error %s: wr_last at beat %0d expected %0b actual %0b",
                     test_name, wr_beats, wr_beats == int'(exp_len) - 1, wr_last);
        end

    a_wr_extra: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && wr_ready |-> (wr_beats < int'(exp_len)))
        else begin
            errors++;
            $display("%s: write beat beyond the job length", test_name);
        end

    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        wr_last |-> wr_valid)
        else begin
            errors++;
            $display("%s: wr_last high without wr_valid", test_name);
        end

    // Done follows the final beat and holds until the next start
    a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(wr_valid && wr_ready && wr_last))
        else begin
            errors++;
            $display("%s: done rose without a final write beat", test_name);
        end

    a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |=> done)
        else begin
            errors++;
            $display("%s: done fell before the next start", test_name);
        end

    a_done_clear: assert property (@(posedge clk) disable iff (!rst_n)
        start_ok |=> !done)
        else begin
            errors++;
            $display("%s: done not cleared by start", test_name);
        end

    // ==============================
    // Stimulus helpers
    // ==============================
    task automatic compare_value(input string what, input logic [DATA_W-1:0] exp_v,
                                 input logic [DATA_W-1:0] act_v);
        assert (act_v === exp_v) else begin
            errors++;
            $display("error %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        errs_before = errors;
        tests_run++;
    endtask

    task automatic end_test;
        if (errors == errs_before) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errs_before);
        end
    endtask

    task automatic check_idle;
        compare_value("rd_cmd_valid", 0, rd_cmd_valid);
        compare_value("wr_cmd_valid", 0, wr_cmd_valid);
        compare_value("wr_valid", 0, wr_valid);
        compare_value("rd_ready", 0, rd_ready);
        compare_value("done", 0, done);
    endtask

    task automatic launch(input accel_op_e f, input logic [ADDR_W-1:0] src,
                          input logic [ADDR_W-1:0] dst, input logic [LEN_W-1:0] len);
        // Lanes of -128, -1, 0 and 127 at the head of the source
        u_dram.mem[src]     = 32'h80FF007F;
        u_dram.mem[src + 1] = 32'h007F80FF;
        @(negedge clk);
        start      = 1'b1;
        start_ok   = 1'b1;
        op         = f;
        src_base   = src;
        dst_base   = dst;
        word_count = len;
        exp_src    = src;
        exp_dst    = dst;
        exp_len    = len;
        @(negedge clk);
        start      = 1'b0;
        start_ok   = 1'b0;
        // Job inputs wander once captured
        src_base   = ADDR_W'($urandom);
        dst_base   = ADDR_W'($urandom);
        word_count = LEN_W'($urandom);
        op         = accel_op_e'($urandom % 4);
    endtask

    task automatic wait_done;
        while (!done) begin
            @(negedge clk);
        end
    endtask

    task automatic check_results(input accel_op_e f, input logic [ADDR_W-1:0] src,
                                 input logic [ADDR_W-1:0] dst, input int len);
        logic [DATA_W-1:0] exp_w;
        for (int i = 0; i < len; i++) begin
            exp_w = ref_word(f, u_dram.mem[src + i]);
            compare_value($sformatf("word %0d", i), exp_w, u_dram.mem[dst + i]);
        end
        compare_value("write beats", len, wr_beats);
        compare_value("read commands", 1, rd_cmds);
        compare_value("write commands", 1, wr_cmds);
    endtask

    task automatic run_job(input accel_op_e f, input logic [ADDR_W-1:0] src,
                           input logic [ADDR_W-1:0] dst, input int len);
        launch(f, src, dst, LEN_W'(len));
        wait_done();
        check_results(f, src, dst, len);
    endtask

    // Start pulse with other fields while a job runs
    task automatic pulse_ignored_start;
        @(negedge clk);
        start      = 1'b1;
        start_busy = 1'b1;
        op         = OP_RELU;
        src_base   = 16'h100;
        dst_base   = 16'h300;
        word_count = 16'd8;
        @(negedge clk);
        start      = 1'b0;
        start_busy = 1'b0;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        void'($urandom(26));
        rst_n        = 1'b0;
        start        = 1'b0;
        op           = OP_COPY;
        src_base     = '0;
        dst_base     = '0;
        word_count   = '0;
        stall_en     = 1'b0;
        start_ok     = 1'b0;
        start_busy   = 1'b0;
        exp_src      = '0;
        exp_dst      = '0;
        exp_len      = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "setup";
        for (int i = 0; i < DEPTH; i++) begin
            u_dram.mem[i] = $urandom;
        end

        begin_test("reset_state");
        repeat (RST_CYC) @(negedge clk);
        check_idle();
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();
        end_test();

        begin_test("copy_16");
        run_job(OP_COPY, 16'h000, 16'h200, 16);
        end_test();

        begin_test("relu_16");
        run_job(OP_RELU, 16'h010, 16'h210, 16);
        end_test();

        begin_test("neg_16");
        run_job(OP_NEG, 16'h020, 16'h220, 16);
        end_test();

        begin_test("abs_16");
        run_job(OP_ABS, 16'h030, 16'h230, 16);
        end_test();

        // Random stalls on every DRAM channel from here on
        stall_en = 1'b1;
        begin_test("neg_64_stalls");
        run_job(OP_NEG, 16'h040, 16'h240, 64);
        end_test();

        begin_test("busy_start_ignored");
        launch(OP_ABS, 16'h080, 16'h280, 16'd32);
        while (wr_beats < 4) begin
            @(negedge clk);
        end
        pulse_ignored_start();
        wait_done();
        check_results(OP_ABS, 16'h080, 16'h280, 32);
        repeat (4) begin
            @(negedge clk);
            compare_value("done while idle", 1, done);
        end
        end_test();

        begin_test("second_job");
        run_job(OP_RELU, 16'h0A0, 16'h2A0, 16);
        repeat (2) @(negedge clk);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/dram_model.sv ====
`timescale 1ns/1ns

module dram_model #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 1024
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall_en,
    input  logic                         rd_cmd_valid,
    output logic                         rd_cmd_ready,
    input  logic [accel_pkg::ADDR_W-1:0] rd_cmd_addr,
    input  logic [accel_pkg::LEN_W-1:0]  rd_cmd_len,
    output logic                         rd_valid,
    input  logic                         rd_ready,
    output logic [DATA_W-1:0]            rd_data,
    output logic                         rd_last,
    input  logic                         wr_cmd_valid,
    output logic                         wr_cmd_ready,
    input  logic [accel_pkg::ADDR_W-1:0] wr_cmd_addr,
    input  logic [accel_pkg::LEN_W-1:0]  wr_cmd_len,
    input  logic                         wr_valid,
    output logic                         wr_ready,
    input  logic [DATA_W-1:0]            wr_data
);

    // Word storage, loaded by the testbench
    logic [DATA_W-1:0] mem [0:DEPTH-1];

    logic rd_active;
    logic wr_active;
    // A read beat moved on the last rising edge
    logic rd_taken;
    int   rd_base;
    int   rd_len;
    int   rd_idx;
    int   wr_base;
    int   wr_len;
    int   wr_idx;

    // Ready or valid for this cycle, one in four lost under stalls
    function automatic logic accept_now();
        return stall_en ? (($urandom % 4) != 0) : 1'b1;
    endfunction

    initial begin
        rd_cmd_ready = 1'b0;
        wr_cmd_ready = 1'b0;
        rd_valid     = 1'b0;
        rd_data      = '0;
        rd_last      = 1'b0;
        wr_ready     = 1'b0;
        rd_active    = 1'b0;
        wr_active    = 1'b0;
        rd_taken     = 1'b0;
        rd_idx       = 0;
        wr_idx       = 0;
    end

    // ==============================
    // Transfers on the rising edge
    // ==============================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_active = 1'b0;
            wr_active = 1'b0;
            rd_taken  = 1'b0;
            rd_idx    = 0;
            wr_idx    = 0;
        end else begin
            // Read engine
            if (rd_cmd_valid && rd_cmd_ready) begin
                rd_active = 1'b1;
                rd_base   = rd_cmd_addr;
                rd_len    = rd_cmd_len;
                rd_idx    = 0;
            end else if (rd_valid && rd_ready) begin
                rd_taken = 1'b1;
                rd_idx++;
                if (rd_idx == rd_len) begin
                    rd_active = 1'b0;
                end
            end
            // Write engine, one word per accepted beat
            if (wr_cmd_valid && wr_cmd_ready) begin
                wr_active = 1'b1;
                wr_base   = wr_cmd_addr;
                wr_len    = wr_cmd_len;
                wr_idx    = 0;
            end else if (wr_valid && wr_ready) begin
                mem[(wr_base + wr_idx) % DEPTH] = wr_data;
                wr_idx++;
                if (wr_idx == wr_len) begin
                    wr_active = 1'b0;
                end
            end
        end
    end

    // ==============================
    // Outputs on the falling edge
    // ==============================
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cmd_ready = 1'b0;
            wr_cmd_ready = 1'b0;
            rd_valid     = 1'b0;
            rd_data      = '0;
            rd_last      = 1'b0;
            wr_ready     = 1'b0;
        end else begin
            rd_cmd_ready = !rd_active && accept_now();
            wr_cmd_ready = !wr_active && accept_now();
            wr_ready     = wr_active && accept_now();
            // Raised valid stays up until the beat moves
            if (!rd_active) begin
                rd_valid = 1'b0;
            end else if (!rd_valid || rd_taken) begin
                rd_valid = accept_now();
            end
            rd_taken = 1'b0;
            rd_data  = rd_active ? mem[(rd_base + rd_idx) % DEPTH] : '0;
            rd_last  = rd_active && (rd_idx == rd_len - 1);
        end
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    // Free running, low for the first half period
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule
